// ==== hw/rf_pkg.sv ====
`default_nettype none

package rf_pkg;

   // Register file geometry
   localparam int RF_XLEN  = 32;
   localparam int RF_WIDTH = 2;
   // 32 GPRs followed by 4 machine CSRs
   localparam int RF_REGS  = 36;
   localparam int RF_DEPTH = RF_REGS * RF_XLEN / RF_WIDTH;
   // Slice index within one register
   localparam int RF_SW    = $clog2(RF_XLEN / RF_WIDTH);
   localparam int RF_AW    = $clog2(RF_DEPTH);

   // CSR selectors inside the CSR block of the RAM
   localparam logic [1:0] CSR_MSCRATCH = 2'd0;
   localparam logic [1:0] CSR_MTVEC    = 2'd1;
   localparam logic [1:0] CSR_MEPC     = 2'd2;
   localparam logic [1:0] CSR_MTVAL    = 2'd3;
   localparam logic [3:0] CSR_TAG      = 4'b1000;

   // Window counter, value n in the n-th cycle after i_rreq
   localparam int               RF_CNT_W    = 6;
   localparam logic [RF_CNT_W-1:0] RF_RDY_CNT  = 6'd3;
   localparam logic [RF_CNT_W-1:0] RF_BIT0_CNT = 6'd4;
   localparam logic [RF_CNT_W-1:0] RF_LAST_CNT = 6'd35;
   // Last write slot, port 1 of slice 15
   localparam logic [RF_CNT_W-1:0] RF_END_CNT  = 6'd37;

   // Register address, either a GPR or a CSR
   typedef union packed {
      struct packed {
         logic       is_csr;
         logic [4:0] idx;
      } gpr;
      struct packed {
         logic [3:0] tag;
         logic [1:0] sel;
      } csr;
   } rf_addr_t;

endpackage

`default_nettype wire

// ==== hw/rf_if.sv ====
`timescale 1ns/10ps
`default_nettype none

module rf_if (
   input  wire              i_clk,
   input  wire              i_rst,
   // Core state
   input  wire              i_run,
   input  wire              i_trap,
   input  wire              i_mret,
   // Trap values
   input  wire              i_mepc,
   input  wire              i_mem_misalign,
   input  wire              i_bufreg_q,
   input  wire              i_bad_pc,
   // CSR access
   input  wire              i_csr_en,
   input  wire [1:0]        i_csr_addr,
   input  wire              i_csr,
   // rd sources
   input  wire              i_rd_wen,
   input  wire [4:0]        i_rd_waddr,
   input  wire              i_ctrl_rd,
   input  wire              i_alu_rd,
   input  wire              i_rd_alu_en,
   input  wire              i_csr_rd,
   input  wire              i_rd_csr_en,
   input  wire              i_mem_rd,
   // Source registers
   input  wire [4:0]        i_rs1_raddr,
   input  wire [4:0]        i_rs2_raddr,
   // Sequencer side
   output rf_pkg::rf_addr_t o_wreg0,
   output rf_pkg::rf_addr_t o_wreg1,
   output logic             o_wen0,
   output logic             o_wen1,
   output logic             o_wdata0,
   output logic             o_wdata1,
   output rf_pkg::rf_addr_t o_rreg0,
   output rf_pkg::rf_addr_t o_rreg1,
   input  wire              i_rdata0,
   input  wire              i_rdata1,
   // Read bits to the core
   output logic             o_rs1,
   output logic             o_rs2,
   output logic             o_csr,
   output logic             o_csr_pc
);

   import rf_pkg::*;

   logic rd_bit;
   logic mtval_bit;

   function automatic rf_addr_t gpr_reg(input logic [4:0] idx);
      rf_addr_t a;
      a.gpr.is_csr = 1'b0;
      a.gpr.idx    = idx;
      return a;
   endfunction

   function automatic rf_addr_t csr_reg(input logic [1:0] sel);
      rf_addr_t a;
      a.csr.tag = CSR_TAG;
      a.csr.sel = sel;
      return a;
   endfunction

   // Merged rd bit from all write-back sources
   assign rd_bit = i_ctrl_rd | (i_alu_rd & i_rd_alu_en) |
                   (i_csr_rd & i_rd_csr_en) | i_mem_rd;

   assign mtval_bit = i_mem_misalign ? i_bufreg_q : i_bad_pc;

   // Port 0 writes rd, or mtval on a trap
   assign o_wdata0 = i_trap ? mtval_bit : rd_bit;
   assign o_wreg0  = i_trap ? csr_reg(CSR_MTVAL) : gpr_reg(i_rd_waddr);
   assign o_wen0   = i_trap | (i_rd_wen & i_run);

   // Port 1 writes the CSR, or mepc on a trap
   assign o_wdata1 = i_trap ? i_mepc : i_csr;
   assign o_wreg1  = i_trap ? csr_reg(CSR_MEPC) : csr_reg(i_csr_addr);
   assign o_wen1   = i_trap | i_csr_en;

   // Read port 0 is always rs1
   assign o_rreg0 = gpr_reg(i_rs1_raddr);

   // Read port 1 shared by the trap vector, mepc, CSRs and rs2
   assign o_rreg1 = i_trap   ? csr_reg(CSR_MTVEC) :
                    i_mret   ? csr_reg(CSR_MEPC)  :
                    i_csr_en ? csr_reg(i_csr_addr) :
                               gpr_reg(i_rs2_raddr);

   assign o_rs1    = i_rdata0;
   assign o_rs2    = i_rdata1;
   assign o_csr    = i_rdata1 & i_csr_en;
   assign o_csr_pc = i_rdata1;

   // Trap writes must land in the CSR block, mtval on port 0 and mepc on port 1
   a_trap_csr_view: assert property (@(posedge i_clk) disable iff (i_rst)
      i_trap |-> (o_wreg0.csr.tag == CSR_TAG) && (o_wreg0.csr.sel == CSR_MTVAL) &&
                 (o_wreg1.csr.tag == CSR_TAG) && (o_wreg1.csr.sel == CSR_MEPC) &&
                 o_wen0 && o_wen1)
      else $error("trap write address outside the CSR block");

endmodule

`default_nettype wire

// ==== hw/rf_ram_if.sv ====
`timescale 1ns/10ps
`default_nettype none

module rf_ram_if (
   input  wire                           i_clk,
   input  wire                           i_rst,
   input  wire                           i_rreq,
   output logic                          o_ready,
   // Bit-serial side
   input  wire rf_pkg::rf_addr_t         i_wreg0,
   input  wire rf_pkg::rf_addr_t         i_wreg1,
   input  wire                           i_wen0,
   input  wire                           i_wen1,
   input  wire                           i_wdata0,
   input  wire                           i_wdata1,
   input  wire rf_pkg::rf_addr_t         i_rreg0,
   input  wire rf_pkg::rf_addr_t         i_rreg1,
   output logic                          o_rdata0,
   output logic                          o_rdata1,
   // RAM side
   output logic [rf_pkg::RF_AW-1:0]      o_waddr,
   output logic [rf_pkg::RF_WIDTH-1:0]   o_wdata,
   output logic                          o_wen,
   output logic [rf_pkg::RF_AW-1:0]      o_raddr,
   input  wire  [rf_pkg::RF_WIDTH-1:0]   i_rdata
);

   import rf_pkg::*;

   logic [RF_CNT_W-1:0] cnt;
   logic                busy;
   rf_addr_t            rreg0_q;
   rf_addr_t            rreg1_q;
   logic [RF_SW-1:0]    rslice;
   logic [RF_WIDTH-1:0] rd0_q;
   logic                rd1_hi;
   logic                in_stream;
   logic                slice_done;
   logic                wport;
   logic [RF_SW-1:0]    wslice;
   logic                wlo0;
   logic                wlo1;
   logic [RF_WIDTH-1:0] wbuf0;
   logic [RF_WIDTH-1:0] wbuf1;
   rf_addr_t            wreg0_q;
   rf_addr_t            wreg1_q;
   logic                wpend0;
   logic                wpend1;

   // Window counter runs from i_rreq until the last write slot
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (i_rreq) begin
         busy <= 1'b1;
         cnt  <= 6'd1;
      end else if (busy) begin
         if (cnt == RF_END_CNT) begin
            busy <= 1'b0;
            cnt  <= '0;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rreg0_q <= '0;
         rreg1_q <= '0;
      end else if (i_rreq) begin
         rreg0_q <= i_rreg0;
         rreg1_q <= i_rreg1;
      end
   end

   assign o_ready = busy && (cnt == RF_RDY_CNT);

   // Even counts fetch port 0 and odd counts fetch port 1
   // Slice s of port 0 is read at 2+2s and of port 1 at 3+2s
   assign rslice  = cnt[RF_SW:1] - 4'd1;
   assign o_raddr = {(cnt[0] ? rreg1_q : rreg0_q), rslice};

   // Port 0 slice arrives one cycle before its first bit
   always_ff @(posedge i_clk) begin
      if (cnt[0]) begin
         rd0_q <= i_rdata;
      end else begin
         rd0_q <= {1'b0, rd0_q[1]};
      end
      // Port 1 low bit goes straight out while the high bit waits a cycle
      if (!cnt[0]) begin
         rd1_hi <= i_rdata[1];
      end
   end

   // Bit k of both ports is on the bus at count 4+k
   assign o_rdata0 = rd0_q[0];
   assign o_rdata1 = cnt[0] ? rd1_hi : i_rdata[0];

   assign in_stream  = busy && (cnt >= RF_BIT0_CNT) && (cnt <= RF_LAST_CNT);
   assign slice_done = in_stream && cnt[0];

   // Collect incoming write bits into slices
   always_ff @(posedge i_clk) begin
      if (!cnt[0]) begin
         wlo0 <= i_wdata0;
         wlo1 <= i_wdata1;
      end
      if (slice_done) begin
         wbuf0   <= {i_wdata0, wlo0};
         wbuf1   <= {i_wdata1, wlo1};
         wreg0_q <= i_wreg0;
         wreg1_q <= i_wreg1;
      end
   end

   // Port 0 writes on even counts and port 1 on odd counts
   assign wport = cnt[0];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wpend0 <= 1'b0;
         wpend1 <= 1'b0;
      end else begin
         if (slice_done && i_wen0) begin
            wpend0 <= 1'b1;
         end else if (!wport) begin
            wpend0 <= 1'b0;
         end
         // Port 1 refills on the same edge that drains it
         if (slice_done && i_wen1) begin
            wpend1 <= 1'b1;
         end else if (wport) begin
            wpend1 <= 1'b0;
         end
      end
   end

   // Slice s completes at 5+2s and is written at 6+2s or 7+2s
   assign wslice  = cnt[RF_SW:1] - 4'd3;
   assign o_wen   = wport ? wpend1 : wpend0;
   assign o_wdata = wport ? wbuf1 : wbuf0;
   assign o_waddr = {(wport ? wreg1_q : wreg0_q), wslice};

   a_rreq_idle: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rreq |-> !busy)
      else $error("i_rreq during an active window");

   // A finished slice must not land on a port 0 slice still waiting
   a_wslice0_free: assert property (@(posedge i_clk) disable iff (i_rst)
      slice_done && i_wen0 |-> !wpend0)
      else $error("port 0 write slice overwritten while pending");

   // A pending port 1 slice keeps its buffer until it is written
   a_wslice1_free: assert property (@(posedge i_clk) disable iff (i_rst)
      wpend1 && !(o_wen && wport) |=> $stable(wbuf1))
      else $error("port 1 write slice overwritten while pending");

endmodule

`default_nettype wire

// ==== hw/rf_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module rf_ram (
   input  wire                          i_clk,
   input  wire  [rf_pkg::RF_AW-1:0]     i_waddr,
   input  wire  [rf_pkg::RF_WIDTH-1:0]  i_wdata,
   input  wire                          i_wen,
   input  wire  [rf_pkg::RF_AW-1:0]     i_raddr,
   output logic [rf_pkg::RF_WIDTH-1:0]  o_rdata
);

   import rf_pkg::*;

   // GPR slices first, CSR slices from word 512 up
   logic [RF_WIDTH-1:0] mem [RF_DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   // Registered read, data valid the cycle after the address
   always_ff @(posedge i_clk) begin
      o_rdata <= mem[i_raddr];
   end

   a_waddr_range: assert property (@(posedge i_clk)
      i_wen |-> (int'(i_waddr) < RF_DEPTH))
      else $error("RAM write address %0d out of range", i_waddr);

   a_raddr_range: assert property (@(posedge i_clk)
      int'(i_raddr) < RF_DEPTH)
      else $error("RAM read address %0d out of range", i_raddr);

endmodule

`default_nettype wire

// ==== hw/rf_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rf_top (
   input  wire       i_clk,
   input  wire       i_rst,
   // Window control
   input  wire       i_rreq,
   output wire       o_ready,
   // Core state and trap values
   input  wire       i_run,
   input  wire       i_trap,
   input  wire       i_mret,
   input  wire       i_mepc,
   input  wire       i_mem_misalign,
   input  wire       i_bufreg_q,
   input  wire       i_bad_pc,
   // CSR access
   input  wire       i_csr_en,
   input  wire [1:0] i_csr_addr,
   input  wire       i_csr,
   // rd write sources
   input  wire       i_rd_wen,
   input  wire [4:0] i_rd_waddr,
   input  wire       i_ctrl_rd,
   input  wire       i_alu_rd,
   input  wire       i_rd_alu_en,
   input  wire       i_csr_rd,
   input  wire       i_rd_csr_en,
   input  wire       i_mem_rd,
   // Read ports
   input  wire [4:0] i_rs1_raddr,
   input  wire [4:0] i_rs2_raddr,
   output wire       o_rs1,
   output wire       o_rs2,
   output wire       o_csr,
   output wire       o_csr_pc
);

   import rf_pkg::*;

   // Bit-serial ports between rf_if and the sequencer
   rf_addr_t wreg0;
   rf_addr_t wreg1;
   rf_addr_t rreg0;
   rf_addr_t rreg1;
   wire      wen0;
   wire      wen1;
   wire      wdata0;
   wire      wdata1;
   wire      rdata0;
   wire      rdata1;

   // RAM port
   wire [RF_AW-1:0]    ram_waddr;
   wire [RF_WIDTH-1:0] ram_wdata;
   wire                ram_wen;
   wire [RF_AW-1:0]    ram_raddr;
   wire [RF_WIDTH-1:0] ram_rdata;

   rf_if u_if (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_run          (i_run),
      .i_trap         (i_trap),
      .i_mret         (i_mret),
      .i_mepc         (i_mepc),
      .i_mem_misalign (i_mem_misalign),
      .i_bufreg_q     (i_bufreg_q),
      .i_bad_pc       (i_bad_pc),
      .i_csr_en       (i_csr_en),
      .i_csr_addr     (i_csr_addr),
      .i_csr          (i_csr),
      .i_rd_wen       (i_rd_wen),
      .i_rd_waddr     (i_rd_waddr),
      .i_ctrl_rd      (i_ctrl_rd),
      .i_alu_rd       (i_alu_rd),
      .i_rd_alu_en    (i_rd_alu_en),
      .i_csr_rd       (i_csr_rd),
      .i_rd_csr_en    (i_rd_csr_en),
      .i_mem_rd       (i_mem_rd),
      .i_rs1_raddr    (i_rs1_raddr),
      .i_rs2_raddr    (i_rs2_raddr),
      .o_wreg0        (wreg0),
      .o_wreg1        (wreg1),
      .o_wen0         (wen0),
      .o_wen1         (wen1),
      .o_wdata0       (wdata0),
      .o_wdata1       (wdata1),
      .o_rreg0        (rreg0),
      .o_rreg1        (rreg1),
      .i_rdata0       (rdata0),
      .i_rdata1       (rdata1),
      .o_rs1          (o_rs1),
      .o_rs2          (o_rs2),
      .o_csr          (o_csr),
      .o_csr_pc       (o_csr_pc)
   );

   rf_ram_if u_ram_if (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_rreq   (i_rreq),
      .o_ready  (o_ready),
      .i_wreg0  (wreg0),
      .i_wreg1  (wreg1),
      .i_wen0   (wen0),
      .i_wen1   (wen1),
      .i_wdata0 (wdata0),
      .i_wdata1 (wdata1),
      .i_rreg0  (rreg0),
      .i_rreg1  (rreg1),
      .o_rdata0 (rdata0),
      .o_rdata1 (rdata1),
      .o_waddr  (ram_waddr),
      .o_wdata  (ram_wdata),
      .o_wen    (ram_wen),
      .o_raddr  (ram_raddr),
      .i_rdata  (ram_rdata)
   );

   rf_ram u_ram (
      .i_clk   (i_clk),
      .i_waddr (ram_waddr),
      .i_wdata (ram_wdata),
      .i_wen   (ram_wen),
      .i_raddr (ram_raddr),
      .o_rdata (ram_rdata)
   );

endmodule

`default_nettype wire

// ==== test/rf_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rf_tb;

   import rf_pkg::*;

   localparam int CLK_PERIOD      = 20;
   localparam int RESET_CYCLES    = 8;
   // 32 fill, 4 GPR, 9 CSR, 5 trap, 1 mret and 3 merge windows
   localparam int WINDOWS         = 54;
   localparam int WINDOW_CYCLES   = 60;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + WINDOWS * WINDOW_CYCLES;
   // Register numbers of the CSR block, after the 32 GPRs
   localparam int CSR_BASE  = 32;
   localparam int REG_MTVEC = 33;
   localparam int REG_MEPC  = 34;
   localparam int REG_MTVAL = 35;

   logic clk;
   logic rst;
   logic rreq;
   logic ready;
   logic run, trap, mret;
   logic mepc, mem_misalign, bufreg_q, bad_pc;
   logic csr_en;
   logic [1:0] csr_addr;
   logic csr;
   logic rd_wen;
   logic [4:0] rd_waddr;
   logic ctrl_rd, alu_rd, rd_alu_en, csr_rd, rd_csr_en, mem_rd;
   logic [4:0] rs1_raddr;
   logic [4:0] rs2_raddr;
   logic rs1_bit, rs2_bit, csr_bit, csr_pc_bit;

   // Bit streams of one window, sent LSB first
   logic [31:0] val_ctrl, val_alu, val_csr_rd, val_mem;
   logic [31:0] val_csr, val_mepc, val_bufreg, val_bad_pc;
   // Reference register model and which entries hold a written value
   logic [31:0] model [36];
   logic        known [36];
   integer      seed;
   int          errors;
   string       test_name;

   rf_top i_dut (
      .i_clk          (clk),
      .i_rst          (rst),
      .i_rreq         (rreq),
      .o_ready        (ready),
      .i_run          (run),
      .i_trap         (trap),
      .i_mret         (mret),
      .i_mepc         (mepc),
      .i_mem_misalign (mem_misalign),
      .i_bufreg_q     (bufreg_q),
      .i_bad_pc       (bad_pc),
      .i_csr_en       (csr_en),
      .i_csr_addr     (csr_addr),
      .i_csr          (csr),
      .i_rd_wen       (rd_wen),
      .i_rd_waddr     (rd_waddr),
      .i_ctrl_rd      (ctrl_rd),
      .i_alu_rd       (alu_rd),
      .i_rd_alu_en    (rd_alu_en),
      .i_csr_rd       (csr_rd),
      .i_rd_csr_en    (rd_csr_en),
      .i_mem_rd       (mem_rd),
      .i_rs1_raddr    (rs1_raddr),
      .i_rs2_raddr    (rs2_raddr),
      .o_rs1          (rs1_bit),
      .o_rs2          (rs2_bit),
      .o_csr          (csr_bit),
      .o_csr_pc       (csr_pc_bit)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic fail_now(input string why);
      errors++;
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else fail_now($sformatf("** Error [%s] %s: expected %0h, actual %0h",
                              test_name, what, exp, act));
   endtask

   task automatic drive_bits(input int k);
      ctrl_rd  <= val_ctrl[k];
      alu_rd   <= val_alu[k];
      csr_rd   <= val_csr_rd[k];
      mem_rd   <= val_mem[k];
      csr      <= val_csr[k];
      mepc     <= val_mepc[k];
      bufreg_q <= val_bufreg[k];
      bad_pc   <= val_bad_pc[k];
   endtask

   // Idle core: running, no writes, x0 on both read ports
   task automatic default_controls();
      val_ctrl   = '0;
      val_alu    = '0;
      val_csr_rd = '0;
      val_mem    = '0;
      val_csr    = '0;
      val_mepc   = '0;
      val_bufreg = '0;
      val_bad_pc = '0;
      run          <= 1'b1;
      trap         <= 1'b0;
      mret         <= 1'b0;
      mem_misalign <= 1'b0;
      csr_en       <= 1'b0;
      csr_addr     <= 2'd0;
      rd_wen       <= 1'b0;
      rd_waddr     <= 5'd0;
      rd_alu_en    <= 1'b0;
      rd_csr_en    <= 1'b0;
      rs1_raddr    <= 5'd0;
      rs2_raddr    <= 5'd0;
      drive_bits(0);
   endtask

   task automatic read_regs(input logic [4:0] a1, input logic [4:0] a2);
      rs1_raddr <= a1;
      rs2_raddr <= a2;
   endtask

   task automatic write_rd(input logic [4:0] a);
      rd_wen   <= 1'b1;
      rd_waddr <= a;
   endtask

   task automatic write_csr(input logic [1:0] sel, input logic [31:0] v);
      csr_en   <= 1'b1;
      csr_addr <= sel;
      val_csr   = v;
   endtask

   task automatic take_trap(input logic misalign);
      trap         <= 1'b1;
      mem_misalign <= misalign;
      val_mepc      = $random(seed);
      val_bufreg    = $random(seed);
      val_bad_pc    = $random(seed);
      // rd sources stay active and must not reach x7
      write_rd(5'd7);
      val_ctrl = $random(seed);
   endtask

   // Port 1 order: mtvec on trap, mepc on mret, CSR, then rs2
   function automatic int port1_reg();
      if (trap)
         return REG_MTVEC;
      if (mret)
         return REG_MEPC;
      if (csr_en)
         return CSR_BASE + int'(csr_addr);
      return int'(rs2_raddr);
   endfunction

   task automatic set_model(input int r, input logic [31:0] v);
      model[r] = v;
      known[r] = 1'b1;
   endtask

   task automatic update_model();
      logic [31:0] rd_val;
      rd_val = val_ctrl | val_mem | (rd_alu_en ? val_alu : 32'd0) |
               (rd_csr_en ? val_csr_rd : 32'd0);
      if (trap) begin
         set_model(REG_MEPC, val_mepc);
         set_model(REG_MTVAL, mem_misalign ? val_bufreg : val_bad_pc);
      end else begin
         if (rd_wen && run)
            set_model(int'(rd_waddr), rd_val);
         if (csr_en)
            set_model(CSR_BASE + int'(csr_addr), val_csr);
      end
   endtask

   // Controls are set on this edge, i_rreq rides along with them
   task automatic run_window();
      int          p1;
      int          waited;
      logic [31:0] exp_rs1;
      logic [31:0] exp_p1;
      logic        chk_rs1;
      logic        chk_p1;
      rreq <= 1'b1;
      @(posedge clk);
      rreq <= 1'b0;
      // Reads see the registers as they were before this window
      p1      = port1_reg();
      exp_rs1 = model[rs1_raddr];
      chk_rs1 = known[rs1_raddr];
      exp_p1  = model[p1];
      chk_p1  = known[p1];
      waited  = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!ready && waited < 8);
      check_value("o_ready delay", 3, waited);
      for (int k = 0; k < 32; k++) begin
         @(posedge clk);
         drive_bits(k);
         @(negedge clk);
         if (k == 0)
            check_value("o_ready pulse end", 0, ready);
         if (chk_rs1)
            check_value($sformatf("o_rs1 bit %0d", k), exp_rs1[k], rs1_bit);
         if (chk_p1) begin
            check_value($sformatf("o_rs2 bit %0d", k), exp_p1[k], rs2_bit);
            check_value($sformatf("o_csr_pc bit %0d", k), exp_p1[k], csr_pc_bit);
            if (csr_en)
               check_value($sformatf("o_csr bit %0d", k), exp_p1[k], csr_bit);
         end
         if (!csr_en)
            check_value($sformatf("o_csr bit %0d", k), 0, csr_bit);
      end
      @(posedge clk);
      update_model();
      default_controls();
      repeat (4) @(posedge clk);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      fail_now($sformatf("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES));
   end

   initial begin
      seed   = 32'h9556865f;
      errors = 0;
      rst    = 1'b1;
      rreq   = 1'b0;
      default_controls();
      for (int r = 0; r < 36; r++) begin
         model[r] = '0;
         known[r] = 1'b0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      test_name = "window timing";
      check_value("o_ready after reset", 0, ready);

      // Every register gets a value, rs1 reads back the previous one
      test_name = "register fill";
      for (int r = 0; r < 32; r++) begin
         @(posedge clk);
         write_rd(r[4:0]);
         rd_alu_en <= 1'b1;
         val_alu    = $random(seed);
         read_regs(5'(r - 1), 5'(r / 2));
         if (r < 4)
            write_csr(r[1:0], $random(seed));
         run_window();
      end

      test_name = "gpr write and read";
      @(posedge clk);
      write_rd(5'd5);
      rd_alu_en <= 1'b1;
      val_alu    = $random(seed);
      read_regs(5'd5, 5'd5);
      run_window();
      // A write with i_run low leaves x5 as it was
      @(posedge clk);
      run <= 1'b0;
      write_rd(5'd5);
      rd_alu_en <= 1'b1;
      val_alu    = ~model[5];
      read_regs(5'd5, 5'd5);
      run_window();
      // ALU bits without their enable
      @(posedge clk);
      write_rd(5'd6);
      val_alu = $random(seed);
      read_regs(5'd5, 5'd5);
      run_window();
      @(posedge clk);
      read_regs(5'd6, 5'd5);
      run_window();

      test_name = "csr access";
      for (int c = 0; c < 4; c++) begin
         @(posedge clk);
         write_csr(c[1:0], $random(seed));
         run_window();
         @(posedge clk);
         write_csr(c[1:0], $random(seed));
         run_window();
      end
      @(posedge clk);
      read_regs(5'd3, 5'd5);
      run_window();

      test_name = "trap";
      @(posedge clk);
      take_trap(1'b1);
      run_window();
      @(posedge clk);
      write_csr(CSR_MEPC, $random(seed));
      read_regs(5'd7, 5'd0);
      run_window();
      @(posedge clk);
      write_csr(CSR_MTVAL, $random(seed));
      run_window();
      @(posedge clk);
      take_trap(1'b0);
      run_window();
      @(posedge clk);
      write_csr(CSR_MTVAL, $random(seed));
      run_window();

      test_name = "mret";
      @(posedge clk);
      mret <= 1'b1;
      read_regs(5'd7, 5'd0);
      run_window();

      test_name = "rd source merge";
      @(posedge clk);
      write_rd(5'd10);
      rd_csr_en <= 1'b1;
      val_ctrl   = $random(seed);
      val_mem    = $random(seed);
      val_csr_rd = $random(seed);
      val_alu    = $random(seed);
      run_window();
      @(posedge clk);
      write_rd(5'd11);
      val_ctrl   = $random(seed);
      val_mem    = $random(seed);
      val_csr_rd = $random(seed);
      run_window();
      @(posedge clk);
      read_regs(5'd10, 5'd11);
      run_window();

      @(posedge clk);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         fail_now("Checks failed during the run");
      end
   end

endmodule

`default_nettype wire

// ==== all.f ====
hw/rf_pkg.sv
hw/rf_if.sv
hw/rf_ram_if.sv
hw/rf_ram.sv
hw/rf_top.sv
test/rf_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module rf_tb -o rf_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/rf_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
   exit 0
fi
exit 1
